// ==== data_ram.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module data_ram import soc_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t req,
  output core_rsp_t rsp
);

  localparam int unsigned WORDS = 2 ** `RAM_ADDR_BITS;

  logic [31:0]               mem [WORDS];
  logic [`RAM_ADDR_BITS-1:0] word_addr;
  logic                      wr_en;

  assign word_addr = req.addr[`RAM_ADDR_BITS-1:0];

  // No write lands while reset is held
  assign wr_en = reset_n && req.cs;

  // ---------------------------------------------------------------------------
  // Byte write
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (req.we[i]) begin
          mem[word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Combinational read, answer in the select cycle
  always_comb begin
    rsp.rdata = mem[word_addr];
    rsp.ready = req.cs;
  end

endmodule

// ==== fw_ram.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module fw_ram import soc_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t req,
  input  logic      app_mode,
  output core_rsp_t rsp
);

  localparam int unsigned WORDS = 2 ** `FW_RAM_ADDR_BITS;

  logic [31:0]                  mem [WORDS];
  logic [`FW_RAM_ADDR_BITS-1:0] word_addr;
  logic                         wr_en;

  assign word_addr = req.addr[`FW_RAM_ADDR_BITS-1:0];

  // Locked once the system runs an application
  assign wr_en = reset_n && req.cs && !app_mode;

  // ---------------------------------------------------------------------------
  // Byte write
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (req.we[i]) begin
          mem[word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Contents hidden in app mode, ready still given so the CPU moves on
  always_comb begin
    rsp.rdata = app_mode ? 32'h0 : mem[word_addr];
    rsp.ready = req.cs;
  end

endmodule

// ==== mem_decoder.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module mem_decoder import soc_pkg::*; (
  input  mem_req_t    bus_req,
  input  logic        bus_ready,
  output core_req_t   ram_req,
  output core_req_t   fw_req,
  output core_req_t   ctrl_req,
  output target_sel_t sel
);

  logic [1:0] area_prefix;
  logic [5:0] core_prefix;
  logic       new_req;
  core_req_t  base_req;

  assign area_prefix = bus_req.addr[31:30];
  assign core_prefix = bus_req.addr[29:24];

  // Ready still high means the current request was already answered
  assign new_req = bus_req.valid && !bus_ready;

  // Shared fields, word address from bit 2 up
  always_comb begin
    base_req.cs    = 1'b0;
    base_req.we    = bus_req.wstrb;
    base_req.addr  = bus_req.addr[17:2];
    base_req.wdata = bus_req.wdata;
  end

  // ---------------------------------------------------------------------------
  // Prefix decode
  // ---------------------------------------------------------------------------
  always_comb begin
    ram_req  = base_req;
    fw_req   = base_req;
    ctrl_req = base_req;
    // No new request, select rests on the data RAM with its cs low
    sel      = SEL_RAM;

    if (new_req) begin
      sel = SEL_NONE;
      case (area_prefix)
        `AREA_RAM: begin
          ram_req.cs = 1'b1;
          sel        = SEL_RAM;
        end
        `AREA_MMIO: begin
          if (core_prefix == `CORE_FW_RAM) begin
            fw_req.cs = 1'b1;
            sel       = SEL_FW_RAM;
          end else if (core_prefix == `CORE_SYS_CTRL) begin
            ctrl_req.cs = 1'b1;
            sel         = SEL_SYS_CTRL;
          end
        end
        // ROM and reserved areas are unmapped here
        `AREA_ROM, `AREA_RESERVED: sel = SEL_NONE;
        default: sel = SEL_NONE;
      endcase
    end
  end

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/100ps

module mem_subsystem import soc_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  mem_req_t    bus_req,
  output logic [31:0] bus_rdata,
  output logic        bus_ready,
  output logic        led_r,
  output logic        led_g,
  output logic        led_b
);

  core_req_t   ram_req;
  core_req_t   fw_req;
  core_req_t   ctrl_req;
  core_rsp_t   ram_rsp;
  core_rsp_t   fw_rsp;
  core_rsp_t   ctrl_rsp;
  target_sel_t sel;
  logic        app_mode;

  // ---------------------------------------------------------------------------
  // Decode
  // ---------------------------------------------------------------------------
  mem_decoder u_decoder (
    .bus_req   (bus_req),
    .bus_ready (bus_ready),
    .ram_req   (ram_req),
    .fw_req    (fw_req),
    .ctrl_req  (ctrl_req),
    .sel       (sel)
  );

  // ---------------------------------------------------------------------------
  // Targets
  // ---------------------------------------------------------------------------
  data_ram u_data_ram (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (ram_req),
    .rsp     (ram_rsp)
  );

  fw_ram u_fw_ram (
    .clk      (clk),
    .reset_n  (reset_n),
    .req      (fw_req),
    .app_mode (app_mode),
    .rsp      (fw_rsp)
  );

  sys_ctrl u_sys_ctrl (
    .clk      (clk),
    .reset_n  (reset_n),
    .req      (ctrl_req),
    .rsp      (ctrl_rsp),
    .app_mode (app_mode),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b)
  );

  // Registered result back to the CPU
  rsp_mux u_rsp_mux (
    .clk       (clk),
    .reset_n   (reset_n),
    .sel       (sel),
    .ram_rsp   (ram_rsp),
    .fw_rsp    (fw_rsp),
    .ctrl_rsp  (ctrl_rsp),
    .bus_rdata (bus_rdata),
    .bus_ready (bus_ready)
  );

endmodule

// ==== mem_subsystem_assert.sv ====
`timescale 1ns/100ps

module mem_subsystem_assert import soc_pkg::*; (
  input logic     clk,
  input logic     reset_n,
  input mem_req_t bus_req,
  input logic     bus_ready,
  input logic     led_r,
  input logic     led_g,
  input logic     led_b
);

  int hold_fails  = 0;
  int rise_fails  = 0;
  int reset_fails = 0;
  int fail_count;

  assign fail_count = hold_fails + rise_fails + reset_fails;

  // ---------------------------------------------------------------------------
  // Bus protocol
  // ---------------------------------------------------------------------------
  ready_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    bus_ready |=> !bus_ready)
    else begin
      hold_fails++;
      $error("bus_ready stayed high for two cycles");
    end

  // Ready only answers a request seen one edge earlier
  ready_after_valid: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(bus_ready) |-> $past(bus_req.valid))
    else begin
      rise_fails++;
      $error("bus_ready rose without valid in the previous cycle");
    end

  idle_after_reset: assert property (@(posedge clk)
    $rose(reset_n) |-> (!bus_ready && !led_r && !led_g && !led_b))
    else begin
      reset_fails++;
      $error("bus_ready or LEDs not low right after reset");
    end

endmodule

bind mem_subsystem mem_subsystem_assert u_assert (
  .clk       (clk),
  .reset_n   (reset_n),
  .bus_req   (bus_req),
  .bus_ready (bus_ready),
  .led_r     (led_r),
  .led_g     (led_g),
  .led_b     (led_b)
);

// ==== rsp_mux.sv ====
`timescale 1ns/100ps

module rsp_mux import soc_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  target_sel_t sel,
  input  core_rsp_t   ram_rsp,
  input  core_rsp_t   fw_rsp,
  input  core_rsp_t   ctrl_rsp,
  output logic [31:0] bus_rdata,
  output logic        bus_ready
);

  core_rsp_t picked;

  // Unmapped access answers at once with zero data
  always_comb begin
    case (sel)
      SEL_RAM:      picked = ram_rsp;
      SEL_FW_RAM:   picked = fw_rsp;
      SEL_SYS_CTRL: picked = ctrl_rsp;
      default:      picked = '{rdata: 32'h0, ready: 1'b1};
    endcase
  end

  // ---------------------------------------------------------------------------
  // Response register
  // ---------------------------------------------------------------------------
  // Idle select points at a target without cs, so ready and data stay low
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bus_rdata <= 32'h0;
      bus_ready <= 1'b0;
    end else begin
      bus_rdata <= picked.ready ? picked.rdata : 32'h0;
      bus_ready <= picked.ready;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f \
    --top-module tb_mem_subsystem -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

exit 0

// ==== sim.f ====
+incdir+.
soc_pkg.sv
mem_decoder.sv
data_ram.sv
fw_ram.sv
sys_ctrl.sv
rsp_mux.sv
mem_subsystem.sv
mem_subsystem_assert.sv
tb_clock_gen.sv
tb_mem_subsystem.sv

// ==== soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------

// Area prefix, address bits 31:30
`define AREA_ROM          2'h0
`define AREA_RAM          2'h1
`define AREA_RESERVED     2'h2
`define AREA_MMIO         2'h3

// MMIO core prefix, address bits 29:24
`define CORE_FW_RAM       6'h10
`define CORE_SYS_CTRL     6'h3f

// ---------------------------------------------------------------------------
// Memory sizes and fixed values
// ---------------------------------------------------------------------------

// Word address widths
`define RAM_ADDR_BITS     10
`define FW_RAM_ADDR_BITS  8

// Read-only name word, "soc1" in ASCII
`define SYS_NAME_WORD     32'h736f6331

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

  // -------------------------------------------------------------------------
  // Bus structs
  // -------------------------------------------------------------------------

  // CPU request, a write when any strobe is set
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  // Request to one target, word addressed
  typedef struct packed {
    logic        cs;
    logic [3:0]  we;
    logic [15:0] addr;
    logic [31:0] wdata;
  } core_req_t;

  // Answer of one target
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } core_rsp_t;

  // -------------------------------------------------------------------------
  // Select and register encodings
  // -------------------------------------------------------------------------

  typedef enum logic [1:0] {
    SEL_NONE     = 2'd0,
    SEL_RAM      = 2'd1,
    SEL_FW_RAM   = 2'd2,
    SEL_SYS_CTRL = 2'd3
  } target_sel_t;

  // System control word addresses
  typedef enum logic [15:0] {
    REG_NAME     = 16'h0000,
    REG_APP_MODE = 16'h0008,
    REG_LED      = 16'h0009,
    REG_SCRATCH  = 16'h0010
  } sys_reg_t;

endpackage

// ==== sys_ctrl.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module sys_ctrl import soc_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t req,
  output core_rsp_t rsp,
  output logic      app_mode,
  output logic      led_r,
  output logic      led_g,
  output logic      led_b
);

  sys_reg_t    reg_addr;
  logic        wr_en;
  logic        app_mode_reg;
  logic [2:0]  led_reg;
  logic [31:0] scratch_reg;

  assign reg_addr = sys_reg_t'(req.addr);
  assign wr_en    = req.cs && (|req.we);

  // ---------------------------------------------------------------------------
  // Control registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode_reg <= 1'b0;
      led_reg      <= 3'b000;
    end else if (wr_en) begin
      case (reg_addr)
        // Sticky until reset
        REG_APP_MODE: if (|req.wdata) app_mode_reg <= 1'b1;
        REG_LED:      led_reg <= req.wdata[2:0];
        default:      ;
      endcase
    end
  end

  // Scratch word, byte strobed
  always_ff @(posedge clk) begin
    if (wr_en && reg_addr == REG_SCRATCH) begin
      for (int i = 0; i < 4; i++) begin
        if (req.we[i]) begin
          scratch_reg[8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Read mux
  always_comb begin
    case (reg_addr)
      REG_NAME:     rsp.rdata = `SYS_NAME_WORD;
      REG_APP_MODE: rsp.rdata = {31'h0, app_mode_reg};
      REG_LED:      rsp.rdata = {29'h0, led_reg};
      REG_SCRATCH:  rsp.rdata = scratch_reg;
      default:      rsp.rdata = 32'h0;
    endcase
    rsp.ready = req.cs;
  end

  assign app_mode = app_mode_reg;

  // Bit 0 red, bit 1 green, bit 2 blue
  assign led_r = led_reg[0];
  assign led_g = led_reg[1];
  assign led_b = led_reg[2];

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

endmodule

// ==== tb_input_vectors.txt ====
# Columns: name op(R/W) addr wdata strobes exp_rdata exp_leds, all hex
# System control words: REG_NAME 0x00, REG_APP_MODE 0x08, REG_LED 0x09, REG_SCRATCH 0x10
ram_wr0      W 40000000 11223344 f 00000000 0
ram_rd0      R 40000000 00000000 0 11223344 0
ram_wr1      W 40000ffc a5a55a5a f 00000000 0
ram_rd1      R 40000ffc 00000000 0 a5a55a5a 0
ram_wr2      W 40000010 deadbeef f 00000000 0
ram_part     W 40000010 00cc00ff 5 00000000 0
ram_rd2      R 40000010 00000000 0 deccbeff 0
unm_wr_a2    W 80000010 12345678 f 00000000 0
unm_wr_a0    W 00000010 12345678 f 00000000 0
unm_wr_core  W c1000010 12345678 f 00000000 0
ram_rd3      R 40000010 00000000 0 deccbeff 0
unm_rd_a0    R 00000010 00000000 0 00000000 0
unm_rd_a2    R 80000010 00000000 0 00000000 0
unm_rd_core  R c1000000 00000000 0 00000000 0
name_rd      R ff000000 00000000 0 736f6331 0
scr_wr       W ff000040 cafef00d f 00000000 0
scr_part     W ff000040 00001200 2 00000000 0
scr_rd       R ff000040 00000000 0 cafe120d 0
led_wr       W ff000024 00000005 f 00000000 5
led_rd       R ff000024 00000000 0 00000005 5
fw_wr        W d0000008 0badf00d f 00000000 5
fw_rd        R d0000008 00000000 0 0badf00d 5
app_rd0      R ff000020 00000000 0 00000000 5
app_wr       W ff000020 00000100 f 00000000 5
app_rd1      R ff000020 00000000 0 00000001 5
fw_rd_app    R d0000008 00000000 0 00000000 5
fw_wr_app    W d0000008 ffffffff f 00000000 5
fw_rd_app2   R d0000008 00000000 0 00000000 5
ram_rd_app   R 40000000 00000000 0 11223344 5

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module tb_mem_subsystem import soc_pkg::*; ();

  logic        clk;
  logic        reset_n;
  mem_req_t    bus_req;
  logic [31:0] bus_rdata;
  logic        bus_ready;
  logic        led_r;
  logic        led_g;
  logic        led_b;

  tb_clock_gen u_clock_gen (
    .clk (clk)
  );

  mem_subsystem UUT (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_req   (bus_req),
    .bus_rdata (bus_rdata),
    .bus_ready (bus_ready),
    .led_r     (led_r),
    .led_g     (led_g),
    .led_b     (led_b)
  );

  // ---------------------------------------------------------------------------
  // Failure reporting
  // ---------------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%0s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input logic [8*24-1:0] name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("** Error: test %0s %0s expected %08h actual %08h",
             name, what, expected, actual);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Reset held for 3 cycles, released on a falling edge
  task automatic apply_reset();
    reset_n = 1'b0;
    bus_req = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  endtask

  // Runs one bus transaction from a falling edge
  task automatic run_transfer(input logic [8*24-1:0] name, input logic [7:0] op,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, input logic [31:0] exp_rdata,
                              input logic [2:0] exp_led);
    int         cycles;
    logic [2:0] led_now;
    bus_req.valid = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.wstrb = (op == "W") ? strb : 4'h0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!bus_ready && cycles < 20);
    if (!bus_ready) begin
      abort_run($sformatf("Timeout: bus_ready never came for test %0s", name));
    end else begin
      led_now = {led_b, led_g, led_r};
      // Write responses carry no defined data
      assert (op == "W" || bus_rdata == exp_rdata)
        else report_mismatch(name, "rdata", exp_rdata, bus_rdata);
      assert (led_now == exp_led)
        else report_mismatch(name, "leds", {29'h0, exp_led}, {29'h0, led_now});
      bus_req = '0;
    end
  endtask

  // ---------------------------------------------------------------------------
  // Vector driven run
  // ---------------------------------------------------------------------------
  initial begin
    int               fd;
    int               idle;
    string            line;
    logic [8*24-1:0]  name_buf;
    logic [7:0]       op;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [3:0]       strb;
    logic [31:0]      exp_rdata;
    logic [2:0]       exp_led;
    logic             fw_keep_seen;
    logic [31:0]      fw_keep_addr;
    logic [31:0]      fw_keep_data;
    void'($urandom(32'hdfe7));
    fw_keep_seen = 1'b0;
    fw_keep_addr = 32'h0;
    fw_keep_data = 32'h0;
    apply_reset();

    fd = $fopen("tb_input_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open tb_input_vectors.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line[0] != "#" && $sscanf(line, "%s %s %h %h %h %h %h", name_buf, op, addr,
                                      wdata, strb, exp_rdata, exp_led) == 7) begin
          run_transfer(name_buf, op, addr, wdata, strb, exp_rdata, exp_led);
          // Nonzero firmware reads come from before app mode
          if (op == "R" && addr[31:30] == `AREA_MMIO && addr[29:24] == `CORE_FW_RAM &&
              exp_rdata != 32'h0) begin
            fw_keep_seen = 1'b1;
            fw_keep_addr = addr;
            fw_keep_data = exp_rdata;
          end
          idle = $urandom % 4;
          repeat (idle) @(negedge clk);
        end
      end
      $fclose(fd);
      // Reset leaves app mode but keeps the firmware RAM contents
      if (fw_keep_seen) begin
        apply_reset();
        run_transfer("fw_kept_reset", "R", fw_keep_addr, 32'h0, 4'h0, fw_keep_data,
                     3'b000);
      end
      repeat (2) @(negedge clk);
      if (UUT.u_assert.fail_count == 0) begin
        $display("Simulation passed");
        $finish;
      end else begin
        $display("Simulation failed");
        $fatal(1);
      end
    end
  end

endmodule
